/* source/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // PC counts in half-words, two per instruction
    localparam word_t INSTR_STEP = 32'd2;
    localparam int PMEM_ADDR_WIDTH = 8;
    localparam int RAM_ADDR_WIDTH = 8;

    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLL  = 6'd6,
        OP_SRL  = 6'd7,
        OP_SLT  = 6'd8,
        OP_ADDI = 6'd9,
        OP_LUI  = 6'd10,
        OP_LW   = 6'd11,
        OP_SW   = 6'd12,
        OP_BEQ  = 6'd13,
        OP_BNE  = 6'd14,
        OP_JAL  = 6'd15,
        OP_JALR = 6'd16,
        OP_OUT  = 6'd17
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_IMM, OP1_PC} operand1_src_e;

    typedef enum logic [2:0] {
        OP2_RS2, OP2_IMM, OP2_CONST_2, OP2_CONST_12, OP2_UPPER_IMM
    } operand2_src_e;

    typedef enum logic {TGT_PC, TGT_RS1} target_src_e;

    typedef enum logic [1:0] {
        NPC_SEQUENTIAL, NPC_BRANCH_ZERO, NPC_BRANCH_NOT_ZERO, NPC_JUMP
    } next_pc_src_e;

    typedef enum logic [1:0] {WB_ALU, WB_RAM, WB_NONE} wb_src_e;

    typedef struct packed {
        reg_addr_t rd;
        alu_op_e alu_op;
        operand1_src_e op1_src;
        operand2_src_e op2_src;
        target_src_e target_src;
        next_pc_src_e next_pc_src;
        wb_src_e wb_src;
        logic reg_write;
        logic ram_write;
        logic stdout_write;
    } ctrl_t;

    typedef struct packed {
        word_t instruction;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        word_t rs1_data;
        word_t rs2_data;
        word_t imm;
        ctrl_t ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        word_t rs1_data;
        word_t rs2_data;
        word_t alu_result;
        logic zero;
        word_t target;
        ctrl_t ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t ram_data;
        word_t alu_result;
        word_t next_pc;
        reg_addr_t rd;
        wb_src_e wb_src;
        logic reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic valid;
        logic [PMEM_ADDR_WIDTH-1:0] index;
        word_t data;
    } prog_write_t;

    typedef struct packed {
        logic pc;
        logic if_id;
        logic id_ex;
        logic ex_mem;
        logic mem_wb;
    } phase_enables_t;

endpackage

/* source/phase_sequencer.sv */
module phase_sequencer (
    input logic clk,
    input logic reset_n,
    input logic run,
    output core_pkg::phase_enables_t enables,
    output logic pipe_reset_n
);

    typedef enum logic [2:0] {
        PH_FETCH, PH_DECODE, PH_EXECUTE, PH_MEMORY, PH_WRITEBACK
    } phase_e;

    phase_e phase;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase <= PH_FETCH;
        end else if (!run || phase == PH_WRITEBACK) begin
            phase <= PH_FETCH;
        end else begin
            phase <= phase_e'(phase + 3'd1);
        end
    end

    // One stage register loads per cycle
    always_comb begin
        enables = '0;
        if (run) begin
            case (phase)
                PH_FETCH:     enables.if_id = 1'b1;
                PH_DECODE:    enables.id_ex = 1'b1;
                PH_EXECUTE:   enables.ex_mem = 1'b1;
                PH_MEMORY:    enables.mem_wb = 1'b1;
                PH_WRITEBACK: enables.pc = 1'b1;
                default:      enables = '0;
            endcase
        end
    end

    // Stage registers and PC held clear while stopped
    assign pipe_reset_n = reset_n && run;

    // Phase never leaves the five legal states while running
    enables_onehot: assert property (
        @(posedge clk) disable iff (!reset_n) run |-> $onehot(enables));

endmodule

/* source/stage_register.sv */
module stage_register #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic reset_n,
    input logic enable,
    input payload_t d,
    output payload_t q
);

    // Holds its value outside the owning phase
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

/* source/program_memory.sv */
module program_memory #(
    parameter int PMEM_ADDR_WIDTH = core_pkg::PMEM_ADDR_WIDTH
) (
    input logic clk,
    input core_pkg::prog_write_t write,
    input core_pkg::word_t pc,
    output core_pkg::word_t instruction
);

    import core_pkg::*;

    word_t mem [2**PMEM_ADDR_WIDTH];
    word_t word_index;

    always_ff @(posedge clk) begin
        if (write.valid) begin
            mem[write.index] <= write.data;
        end
    end

    assign word_index = pc / INSTR_STEP;
    assign instruction = mem[word_index[PMEM_ADDR_WIDTH-1:0]];

endmodule

/* source/decoder.sv */
module decoder (
    input core_pkg::word_t instruction,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::word_t imm,
    output core_pkg::ctrl_t ctrl
);

    import core_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instruction[31:26]);
    assign rs2 = instruction[15:11];
    assign imm = {{16{instruction[15]}}, instruction[15:0]};

    // LUI reads r0 so the ALU adds zero to the shifted immediate
    assign rs1 = (opcode == OP_LUI) ? 5'd0 : instruction[20:16];

    always_comb begin
        ctrl = '0;
        ctrl.rd = instruction[25:21];
        ctrl.alu_op = ALU_ADD;
        ctrl.op1_src = OP1_RS1;
        ctrl.op2_src = OP2_RS2;
        ctrl.target_src = TGT_PC;
        ctrl.next_pc_src = NPC_SEQUENTIAL;
        ctrl.wb_src = WB_NONE;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT: begin
                ctrl.alu_op = alu_op_e'(opcode - OP_ADD);
                ctrl.wb_src = WB_ALU;
                ctrl.reg_write = 1'b1;
            end
            OP_ADDI: begin
                ctrl.op2_src = OP2_IMM;
                ctrl.wb_src = WB_ALU;
                ctrl.reg_write = 1'b1;
            end
            OP_LUI: begin
                ctrl.op2_src = OP2_UPPER_IMM;
                ctrl.wb_src = WB_ALU;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ctrl.op2_src = OP2_IMM;
                ctrl.wb_src = WB_RAM;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.op2_src = OP2_IMM;
                ctrl.ram_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.next_pc_src = (opcode == OP_BEQ) ? NPC_BRANCH_ZERO : NPC_BRANCH_NOT_ZERO;
            end
            OP_JAL, OP_JALR: begin
                // Link value is the following instruction
                ctrl.op1_src = OP1_PC;
                ctrl.op2_src = OP2_CONST_2;
                ctrl.target_src = (opcode == OP_JALR) ? TGT_RS1 : TGT_PC;
                ctrl.next_pc_src = NPC_JUMP;
                ctrl.wb_src = WB_ALU;
                ctrl.reg_write = 1'b1;
            end
            OP_OUT: ctrl.stdout_write = 1'b1;
            default: ;
        endcase
    end

endmodule

/* source/register_file.sv */
module register_file (
    input logic clk,
    input logic reset_n,
    input logic write_enable,
    input core_pkg::reg_addr_t read_address1,
    input core_pkg::reg_addr_t read_address2,
    input core_pkg::reg_addr_t write_address,
    input core_pkg::word_t write_data,
    output core_pkg::word_t read_data1,
    output core_pkg::word_t read_data2
);

    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != 5'd0) begin
            regs[write_address] <= write_data;
        end
    end

    // r0 reads zero whatever sits in the array
    assign read_data1 = (read_address1 == 5'd0) ? '0 : regs[read_address1];
    assign read_data2 = (read_address2 == 5'd0) ? '0 : regs[read_address2];

endmodule

/* source/execute_unit.sv */
module execute_unit (
    input core_pkg::id_ex_t stage,
    output core_pkg::ex_mem_t result
);

    import core_pkg::*;

    word_t operand1;
    word_t operand2;
    word_t target_base;
    word_t alu_result;

    always_comb begin
        case (stage.ctrl.op1_src)
            OP1_RS1: operand1 = stage.rs1_data;
            OP1_IMM: operand1 = stage.imm;
            OP1_PC:  operand1 = stage.pc;
            default: operand1 = '0;
        endcase
    end

    always_comb begin
        case (stage.ctrl.op2_src)
            OP2_RS2:       operand2 = stage.rs2_data;
            OP2_IMM:       operand2 = stage.imm;
            OP2_CONST_2:   operand2 = 32'd2;
            OP2_CONST_12:  operand2 = 32'd12;
            OP2_UPPER_IMM: operand2 = stage.imm << 12;
            default:       operand2 = '0;
        endcase
    end

    // Result ALU
    always_comb begin
        case (stage.ctrl.alu_op)
            ALU_ADD: alu_result = operand1 + operand2;
            ALU_SUB: alu_result = operand1 - operand2;
            ALU_AND: alu_result = operand1 & operand2;
            ALU_OR:  alu_result = operand1 | operand2;
            ALU_XOR: alu_result = operand1 ^ operand2;
            ALU_SLL: alu_result = operand1 << operand2[4:0];
            ALU_SRL: alu_result = operand1 >> operand2[4:0];
            ALU_SLT: alu_result = {31'd0, $signed(operand1) < $signed(operand2)};
            default: alu_result = '0;
        endcase
    end

    // Branch and jump target
    assign target_base = (stage.ctrl.target_src == TGT_RS1) ? stage.rs1_data : stage.pc;

    always_comb begin
        result.pc = stage.pc;
        result.rs1_data = stage.rs1_data;
        result.rs2_data = stage.rs2_data;
        result.alu_result = alu_result;
        result.zero = (alu_result == '0);
        result.target = target_base + stage.imm;
        result.ctrl = stage.ctrl;
    end

endmodule

/* source/memory_stage.sv */
module memory_stage #(
    parameter int RAM_ADDR_WIDTH = core_pkg::RAM_ADDR_WIDTH
) (
    input logic clk,
    input logic reset_n,
    input logic enable,
    input core_pkg::ex_mem_t stage,
    output core_pkg::mem_wb_t result,
    output logic stdout_valid,
    output logic [7:0] stdout_data
);

    import core_pkg::*;

    word_t ram [2**RAM_ADDR_WIDTH];
    logic [RAM_ADDR_WIDTH-1:0] ram_index;
    word_t sequential_pc;
    word_t next_pc;

    assign ram_index = stage.alu_result[RAM_ADDR_WIDTH-1:0];
    assign sequential_pc = stage.pc + INSTR_STEP;

    always_comb begin
        case (stage.ctrl.next_pc_src)
            NPC_BRANCH_ZERO:     next_pc = stage.zero ? stage.target : sequential_pc;
            NPC_BRANCH_NOT_ZERO: next_pc = stage.zero ? sequential_pc : stage.target;
            NPC_JUMP:            next_pc = stage.target;
            default:             next_pc = sequential_pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable && stage.ctrl.ram_write) begin
            ram[ram_index] <= stage.rs2_data;
        end
    end

    always_comb begin
        result.ram_data = ram[ram_index];
        result.alu_result = stage.alu_result;
        result.next_pc = next_pc;
        result.rd = stage.ctrl.rd;
        result.wb_src = stage.ctrl.wb_src;
        result.reg_write = stage.ctrl.reg_write;
    end

    // Strobe lands in the writeback cycle of OUT
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stdout_valid <= 1'b0;
        end else begin
            stdout_valid <= enable && stage.ctrl.stdout_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            stdout_data <= stage.rs1_data[7:0];
        end
    end

    stdout_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n) stdout_valid |=> !stdout_valid);

endmodule

/* source/miyajiro_core.sv */
module miyajiro_core #(
    parameter int PMEM_ADDR_WIDTH = core_pkg::PMEM_ADDR_WIDTH,
    parameter int RAM_ADDR_WIDTH = core_pkg::RAM_ADDR_WIDTH
) (
    input logic clk,
    input logic reset_n,
    input logic run,
    input core_pkg::prog_write_t prog_write,
    output logic stdout_valid,
    output logic [7:0] stdout_data
);

    import core_pkg::*;

    phase_enables_t enables;
    logic pipe_reset_n;
    word_t pc;
    word_t instruction;
    if_id_t if_id_d;
    if_id_t if_id_q;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t wb_data;

    phase_sequencer sequencer_i (
        .clk(clk),
        .reset_n(reset_n),
        .run(run),
        .enables(enables),
        .pipe_reset_n(pipe_reset_n)
    );

    // PC loads the next pc at the end of writeback
    stage_register #(.payload_t(word_t)) pc_reg_i (
        .clk(clk), .reset_n(pipe_reset_n), .enable(enables.pc),
        .d(mem_wb_q.next_pc), .q(pc)
    );

    program_memory #(.PMEM_ADDR_WIDTH(PMEM_ADDR_WIDTH)) program_memory_i (
        .clk(clk),
        .write(prog_write),
        .pc(pc),
        .instruction(instruction)
    );

    assign if_id_d = '{instruction: instruction, pc: pc};

    stage_register #(.payload_t(if_id_t)) if_id_reg_i (
        .clk(clk), .reset_n(pipe_reset_n), .enable(enables.if_id), .d(if_id_d), .q(if_id_q)
    );

    decoder decoder_i (
        .instruction(if_id_q.instruction),
        .rs1(rs1),
        .rs2(rs2),
        .imm(id_ex_d.imm),
        .ctrl(id_ex_d.ctrl)
    );

    register_file register_file_i (
        .clk(clk),
        .reset_n(reset_n),
        .write_enable(enables.pc && mem_wb_q.reg_write),
        .read_address1(rs1),
        .read_address2(rs2),
        .write_address(mem_wb_q.rd),
        .write_data(wb_data),
        .read_data1(id_ex_d.rs1_data),
        .read_data2(id_ex_d.rs2_data)
    );

    assign id_ex_d.pc = if_id_q.pc;

    stage_register #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk(clk), .reset_n(pipe_reset_n), .enable(enables.id_ex), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit execute_unit_i (
        .stage(id_ex_q),
        .result(ex_mem_d)
    );

    stage_register #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .clk(clk), .reset_n(pipe_reset_n), .enable(enables.ex_mem), .d(ex_mem_d), .q(ex_mem_q)
    );

    memory_stage #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) memory_stage_i (
        .clk(clk),
        .reset_n(reset_n),
        .enable(enables.mem_wb),
        .stage(ex_mem_q),
        .result(mem_wb_d),
        .stdout_valid(stdout_valid),
        .stdout_data(stdout_data)
    );

    stage_register #(.payload_t(mem_wb_t)) mem_wb_reg_i (
        .clk(clk), .reset_n(pipe_reset_n), .enable(enables.mem_wb), .d(mem_wb_d), .q(mem_wb_q)
    );

    // Writeback data select
    always_comb begin
        case (mem_wb_q.wb_src)
            WB_ALU:  wb_data = mem_wb_q.alu_result;
            WB_RAM:  wb_data = mem_wb_q.ram_data;
            default: wb_data = '0;
        endcase
    end

    load_only_when_stopped: assert property (
        @(posedge clk) disable iff (!reset_n) run |-> !prog_write.valid);

endmodule

/* verification/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int PROG_WORDS = 64;
localparam int RUN_INSTRS = 200;
localparam int DATA_WORDS = 4;

logic [31:0] lcg_state;
word_t program_words [PROG_WORDS];
word_t ref_regs [32];
word_t ref_ram [2**RAM_ADDR_WIDTH];
word_t ref_pc;

// Expected stdout bytes, with the instruction number that printed each
logic [7:0] expected_bytes [$];
int expected_instrs [$];

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
endfunction

function automatic word_t encode_instr(logic [5:0] op, reg_addr_t rd, reg_addr_t rs1,
                                       logic [15:0] imm);
    return {op, rd, rs1, imm};
endfunction

// r7 is only ever loaded with a valid program address, so JALR through it stays inside
function automatic void build_program();
    int kind;
    int target;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    for (int i = 0; i < PROG_WORDS; i++) begin
        rd = 5'(next_random() % 7);
        rs1 = 5'(next_random() % 8);
        rs2 = 5'(next_random() % 8);
        target = int'(next_random() % PROG_WORDS);
        kind = int'(next_random() % 18);
        if (i < DATA_WORDS) begin
            // Prologue fills every RAM word that a load can reach
            program_words[i] = encode_instr(OP_SW, 5'd0, 5'd0, {rs2, 3'd0, 8'(i)});
        end else if (i == PROG_WORDS - 1) begin
            program_words[i] = encode_instr(OP_JAL, 5'd0, 5'd0, 16'(-2 * i));
        end else begin
            case (kind)
                0, 1, 2: program_words[i] = encode_instr(6'(OP_ADD + next_random() % 8),
                                                         rd, rs1, {rs2, 11'd0});
                3: program_words[i] = encode_instr(OP_ADDI, rd, rs1, 16'(next_random()));
                4: program_words[i] = encode_instr(OP_LUI, rd, rs1, 16'(next_random()));
                5: program_words[i] = encode_instr(OP_LW, rd, 5'd0,
                                                   16'(next_random() % DATA_WORDS));
                6: program_words[i] = encode_instr(OP_SW, 5'd0, 5'd0,
                                                   {rs2, 3'd0, 8'(next_random() % DATA_WORDS)});
                // Branch offset shares bits with rs2, so the target is reached modulo 256 words
                7: program_words[i] = encode_instr(OP_BEQ, 5'd0, rs1,
                                                   {rs2, 11'(2 * ((target - i) & 255))});
                8: program_words[i] = encode_instr(OP_BNE, 5'd0, rs1,
                                                   {rs2, 11'(2 * ((target - i) & 255))});
                9: program_words[i] = encode_instr(OP_JAL, rd, 5'd0, 16'(2 * (target - i)));
                10: program_words[i] = encode_instr(OP_ADDI, 5'd7, 5'd0, 16'(2 * target));
                11: program_words[i] = encode_instr(OP_JALR, rd, 5'd7, 16'd0);
                12: program_words[i] = encode_instr(OP_NOP, rd, rs1, 16'd0);
                13: program_words[i] = encode_instr(6'(18 + next_random() % 46), rd, rs1,
                                                    16'(next_random()));
                default: program_words[i] = encode_instr(OP_OUT, 5'd0, rs1, 16'd0);
            endcase
        end
    end
endfunction

function automatic void write_reg(reg_addr_t rd, word_t value);
    if (rd != 5'd0) begin
        ref_regs[rd] = value;
    end
endfunction

function automatic void step_model(int instr_count);
    word_t instr;
    word_t a;
    word_t b;
    word_t imm;
    word_t next_pc;
    logic [5:0] op;
    reg_addr_t rd;
    instr = program_words[ref_pc[6:1]];
    op = instr[31:26];
    rd = instr[25:21];
    a = ref_regs[instr[20:16]];
    b = ref_regs[instr[15:11]];
    imm = {{16{instr[15]}}, instr[15:0]};
    next_pc = ref_pc + 32'd2;
    case (op)
        OP_ADD:  write_reg(rd, a + b);
        OP_SUB:  write_reg(rd, a - b);
        OP_AND:  write_reg(rd, a & b);
        OP_OR:   write_reg(rd, a | b);
        OP_XOR:  write_reg(rd, a ^ b);
        OP_SLL:  write_reg(rd, a << b[4:0]);
        OP_SRL:  write_reg(rd, a >> b[4:0]);
        OP_SLT:  write_reg(rd, {31'd0, $signed(a) < $signed(b)});
        OP_ADDI: write_reg(rd, a + imm);
        OP_LUI:  write_reg(rd, imm << 12);
        OP_LW:   write_reg(rd, ref_ram[8'(a + imm)]);
        OP_SW:   ref_ram[8'(a + imm)] = b;
        OP_BEQ:  next_pc = (a == b) ? ref_pc + imm : next_pc;
        OP_BNE:  next_pc = (a != b) ? ref_pc + imm : next_pc;
        OP_JAL: begin
            next_pc = ref_pc + imm;
            write_reg(rd, ref_pc + 32'd2);
        end
        OP_JALR: begin
            next_pc = a + imm;
            write_reg(rd, ref_pc + 32'd2);
        end
        OP_OUT: begin
            expected_bytes.push_back(a[7:0]);
            expected_instrs.push_back(instr_count);
        end
        default: next_pc = ref_pc + 32'd2;
    endcase
    ref_pc = next_pc;
endfunction

`endif

/* verification/core_tb.sv */
module core_tb;

    import core_pkg::*;

    logic clk;
    logic reset_n;
    logic run;
    prog_write_t prog_write;
    logic stdout_valid;
    logic [7:0] stdout_data;
    int cycle_count;

    `include "core_model.svh"

    localparam int ROUNDS = 4;
    localparam int CYCLES_PER_INSTR = 5;
    localparam int TIMEOUT_CYCLES =
        ROUNDS * (PROG_WORDS + RUN_INSTRS * CYCLES_PER_INSTR + 20);

    miyajiro_core dut_i (
        .clk(clk),
        .reset_n(reset_n),
        .run(run),
        .prog_write(prog_write),
        .stdout_valid(stdout_valid),
        .stdout_data(stdout_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic report_failure(string message);
        $display("[FAIL] %0t: %s", $time, message);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // Core is stopped, so no strobe may appear while words go in
    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            assert (!stdout_valid)
                else report_failure("stdout_valid high while the program is loaded");
            prog_write.valid = 1'b1;
            prog_write.index = i[PMEM_ADDR_WIDTH-1:0];
            prog_write.data = program_words[i];
        end
        @(negedge clk);
        prog_write = '0;
    endtask

    task automatic check_strobe(int cycle);
        assert (expected_bytes.size() > 0)
            else report_failure($sformatf("unexpected stdout strobe in cycle %0d", cycle));
        assert (cycle == CYCLES_PER_INSTR * expected_instrs[0] + 4)
            else report_failure($sformatf("strobe cycle expected %0d, actual %0d",
                                          CYCLES_PER_INSTR * expected_instrs[0] + 4, cycle));
        assert (stdout_data == expected_bytes[0])
            else report_failure($sformatf("stdout byte expected 0x%02h, actual 0x%02h",
                                          expected_bytes[0], stdout_data));
        void'(expected_bytes.pop_front());
        void'(expected_instrs.pop_front());
    endtask

    // Cycle 0 is the fetch of instruction 0; run drops in the fetch after the last one
    task automatic run_program();
        @(negedge clk);
        run = 1'b1;
        for (int c = 1; c <= RUN_INSTRS * CYCLES_PER_INSTR; c++) begin
            @(negedge clk);
            if (stdout_valid) begin
                check_strobe(c);
            end
        end
        run = 1'b0;
        assert (expected_bytes.size() == 0)
            else report_failure($sformatf("%0d stdout bytes expected but never seen",
                                          expected_bytes.size()));
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        run = 1'b0;
        prog_write = '0;
        cycle_count = 0;
        lcg_state = 32'd25;
        ref_pc = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        // Registers and RAM carry over between rounds in both DUT and model
        for (int round = 0; round < ROUNDS; round++) begin
            build_program();
            ref_pc = '0;
            for (int n = 0; n < RUN_INSTRS; n++) begin
                step_model(n);
            end
            load_program();
            run_program();
        end

        @(negedge clk);
        assert (!stdout_valid) else report_failure("stdout_valid high after the last run");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* miyajiro_core.f */
+incdir+verification
source/core_pkg.sv
source/phase_sequencer.sv
source/stage_register.sv
source/program_memory.sv
source/decoder.sv
source/register_file.sv
source/execute_unit.sv
source/memory_stage.sv
source/miyajiro_core.sv
verification/core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f miyajiro_core.f -o core_sim

output=$(./obj_dir/core_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
